//--- x86_flags_consts.svh
/*
 * x86 flags pipeline constants
 * Data and EFLAGS widths plus the bit positions of the modeled flags
 */
`ifndef X86_FLAGS_CONSTS_SVH
`define X86_FLAGS_CONSTS_SVH

// Operand and result width
`define XF_DATA_W       32

// Modeled EFLAGS image, bits 17..9 and 6..5 are reserved
`define XF_EFLAGS_W     18

// Status and control flag positions within the image
`define XF_CF_BIT       0
`define XF_PF_BIT       1
`define XF_AF_BIT       2
`define XF_ZF_BIT       3
`define XF_SF_BIT       4
`define XF_DF_BIT       7
`define XF_OF_BIT       8

// All seven defined flags, used to clean a popped image
`define XF_DEFINED_MASK 18'h0019F

`endif

//--- x86_flags_pkg.sv
/*
 * x86 flags pipeline types
 * Operation codes accepted at issue and the EFLAGS image type
 */
`include "x86_flags_consts.svh"

package x86_flags_pkg;

    // Operations handled by the flags pipeline
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,   // No result, no flag change
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_CMP  = 4'd3,   // SUB without a result
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_INC  = 4'd7,   // Implied operand of 1, CF untouched
        OP_DEC  = 4'd8,   // Implied operand of 1, CF untouched
        OP_CLD  = 4'd9,   // DF cleared
        OP_STD  = 4'd10,  // DF set
        OP_POPF = 4'd11   // Image loaded from src2
    } alu_op_e;

    // 18-bit flags image, layout
    // 000000000_of_df_00_sf_zf_af_pf_cf
    typedef logic [`XF_EFLAGS_W-1:0] eflags_t;

endpackage

//--- flag_gen.sv
/*
 * flag_gen: result and flag computation for one operation
 * Combinational, produces CF/PF/AF/ZF/SF/OF and DF for the issued op
 */
`timescale 1ns/1ps
`include "x86_flags_consts.svh"

module flag_gen (
    input  x86_flags_pkg::alu_op_e op,
    input  logic [`XF_DATA_W-1:0]  src1,
    input  logic [`XF_DATA_W-1:0]  src2,
    output logic [`XF_DATA_W-1:0]  result,
    output x86_flags_pkg::eflags_t cc
);
    import x86_flags_pkg::*;

    localparam int MSB = `XF_DATA_W - 1;

    logic [`XF_DATA_W-1:0] opb;       // Second operand after INC/DEC substitution
    logic                  is_unit;   // INC or DEC
    logic                  is_sub;    // Subtract path, borrow in CF
    logic [`XF_DATA_W:0]   arith;     // Sum or difference with carry out on top
    logic                  arith_of;  // Signed overflow of the arith path
    logic                  arith_af;  // Carry or borrow out of bit 3

    assign is_unit = (op == OP_INC) || (op == OP_DEC);
    assign is_sub  = (op == OP_SUB) || (op == OP_CMP) || (op == OP_DEC);

    assign opb = is_unit ? {{(`XF_DATA_W-1){1'b0}}, 1'b1} : src2;

    always_comb begin
        if (is_sub) begin
            arith = {1'b0, src1} - {1'b0, opb};  // Top bit is the borrow
        end else begin
            arith = {1'b0, src1} + {1'b0, opb};
        end
    end

    // Overflow when the sign of the result cannot follow from the operand signs
    always_comb begin
        if (is_sub) begin
            arith_of = (src1[MSB] != opb[MSB]) && (arith[MSB] != src1[MSB]);
        end else begin
            arith_of = (src1[MSB] == opb[MSB]) && (arith[MSB] != src1[MSB]);
        end
    end

    // Bit 4 of a^b^r tells whether bit 3 carried or borrowed
    assign arith_af = src1[4] ^ opb[4] ^ arith[4];

    always_comb begin
        cc     = '0;
        result = '0;

        case (op)
            OP_ADD, OP_SUB, OP_CMP, OP_INC, OP_DEC: begin
                result          = arith[MSB:0];  // CMP keeps it for the flags only
                cc[`XF_CF_BIT]  = arith[`XF_DATA_W];
                cc[`XF_AF_BIT]  = arith_af;
                cc[`XF_OF_BIT]  = arith_of;
            end
            OP_AND: begin
                result = src1 & src2;
            end
            OP_OR: begin
                result = src1 | src2;
            end
            OP_XOR: begin
                result = src1 ^ src2;
            end
            OP_STD: begin
                cc[`XF_DF_BIT] = 1'b1;
            end
            default: begin
                result = '0;  // CLD, POPF and NOP carry no result
            end
        endcase

        // Result-derived flags, masked off later for ops that do not write them
        cc[`XF_PF_BIT] = ~^result[7:0];
        cc[`XF_ZF_BIT] = (result == '0);
        cc[`XF_SF_BIT] = result[MSB];
    end

endmodule

//--- alu_flag_stage.sv
/*
 * alu_flag_stage: pipeline stage 1
 * Registers the issued op with its result, new flags, write mask and pop image
 */
`timescale 1ns/1ps
`include "x86_flags_consts.svh"

module alu_flag_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   val,
    input  x86_flags_pkg::alu_op_e op,
    input  logic [`XF_DATA_W-1:0]  src1,
    input  logic [`XF_DATA_W-1:0]  src2,
    output logic                   s1_val,
    output logic [`XF_DATA_W-1:0]  s1_result,
    output logic                   s1_wr_result,
    output x86_flags_pkg::eflags_t s1_cc_new,
    output x86_flags_pkg::eflags_t s1_fmask,
    output logic                   s1_pop,
    output x86_flags_pkg::eflags_t s1_pop_image
);
    import x86_flags_pkg::*;

    // CF, PF, AF, ZF, SF and OF
    localparam eflags_t ARITH_MASK = eflags_t'((1 << `XF_CF_BIT) | (1 << `XF_PF_BIT) |
                                               (1 << `XF_AF_BIT) | (1 << `XF_ZF_BIT) |
                                               (1 << `XF_SF_BIT) | (1 << `XF_OF_BIT));
    localparam eflags_t LOGIC_MASK  = ARITH_MASK & ~eflags_t'(1 << `XF_AF_BIT);
    localparam eflags_t UNIT_MASK   = ARITH_MASK & ~eflags_t'(1 << `XF_CF_BIT);
    localparam eflags_t DF_MASK     = eflags_t'(1 << `XF_DF_BIT);

    logic [`XF_DATA_W-1:0] gen_result;
    eflags_t               gen_cc;
    eflags_t               fmask;
    logic                  wr_result;
    logic                  pop;

    flag_gen u_flag_gen (
        .op     (op),
        .src1   (src1),
        .src2   (src2),
        .result (gen_result),
        .cc     (gen_cc)
    );

    // Per-op write mask and result enable
    always_comb begin
        fmask     = '0;
        wr_result = 1'b0;
        pop       = 1'b0;

        case (op)
            OP_ADD, OP_SUB: begin
                fmask     = ARITH_MASK;
                wr_result = 1'b1;
            end
            OP_CMP:                 fmask = ARITH_MASK;
            OP_AND, OP_OR, OP_XOR: begin
                fmask     = LOGIC_MASK;  // AF left as it was
                wr_result = 1'b1;
            end
            OP_INC, OP_DEC: begin
                fmask     = UNIT_MASK;
                wr_result = 1'b1;
            end
            OP_CLD, OP_STD:         fmask = DF_MASK;
            OP_POPF:                pop   = 1'b1;
            default:                fmask = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_val <= 1'b0;
        end else begin
            s1_val <= val;
        end
    end

    // Payload only moves with a valid issue
    always_ff @(posedge clk) begin
        if (val) begin
            s1_result    <= gen_result;
            s1_wr_result <= wr_result;
            s1_cc_new    <= gen_cc;
            s1_fmask     <= fmask;
            s1_pop       <= pop;
            s1_pop_image <= src2[`XF_EFLAGS_W-1:0] & `XF_DEFINED_MASK;
        end
    end

endmodule

//--- eflags_reg.sv
/*
 * eflags_reg: pipeline stage 2
 * EFLAGS register with masked update, pop load and invalidate, plus result output
 */
`timescale 1ns/1ps
`include "x86_flags_consts.svh"

module eflags_reg (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   s1_val,
    input  logic [`XF_DATA_W-1:0]  s1_result,
    input  logic                   s1_wr_result,
    input  x86_flags_pkg::eflags_t s1_cc_new,
    input  x86_flags_pkg::eflags_t s1_fmask,
    input  logic                   s1_pop,
    input  x86_flags_pkg::eflags_t s1_pop_image,
    input  logic                   cc_inval,
    output x86_flags_pkg::eflags_t cc_out,
    output logic [`XF_DATA_W-1:0]  result,
    output logic                   result_val
);
    import x86_flags_pkg::*;

    logic    commit;   // Stage-2 op survives the squash
    logic    res_load;
    eflags_t cc_next;

    assign commit   = s1_val && !cc_inval;
    assign res_load = commit && s1_wr_result;

    // Per-bit select of old value, new flag or popped image
    always_comb begin
        for (int i = 0; i < `XF_EFLAGS_W; i++) begin
            if (s1_pop) begin
                cc_next[i] = s1_pop_image[i];
            end else if (s1_fmask[i]) begin
                cc_next[i] = s1_cc_new[i];
            end else begin
                cc_next[i] = cc_out[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cc_out     <= '0;
            result     <= '0;
            result_val <= 1'b0;
        end else begin
            result_val <= res_load;  // One-cycle pulse per committed result
            if (commit) begin
                cc_out <= cc_next;
            end
            if (res_load) begin
                result <= s1_result;
            end
        end
    end

endmodule

//--- x86_flags_top.sv
/*
 * x86_flags_top: two-stage flags pipeline
 * Issue port into stage 1, EFLAGS and result out of stage 2
 */
`timescale 1ns/1ps
`include "x86_flags_consts.svh"

module x86_flags_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   val,
    input  x86_flags_pkg::alu_op_e op,
    input  logic [`XF_DATA_W-1:0]  src1,
    input  logic [`XF_DATA_W-1:0]  src2,
    input  logic                   cc_inval,
    output x86_flags_pkg::eflags_t cc_out,
    output logic [`XF_DATA_W-1:0]  result,
    output logic                   result_val
);
    import x86_flags_pkg::*;

    // Stage 1 to stage 2
    logic                  s1_val;
    logic [`XF_DATA_W-1:0] s1_result;
    logic                  s1_wr_result;
    eflags_t               s1_cc_new;
    eflags_t               s1_fmask;
    logic                  s1_pop;
    eflags_t               s1_pop_image;

    alu_flag_stage u_alu_flag_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .val          (val),
        .op           (op),
        .src1         (src1),
        .src2         (src2),
        .s1_val       (s1_val),
        .s1_result    (s1_result),
        .s1_wr_result (s1_wr_result),
        .s1_cc_new    (s1_cc_new),
        .s1_fmask     (s1_fmask),
        .s1_pop       (s1_pop),
        .s1_pop_image (s1_pop_image)
    );

    eflags_reg u_eflags_reg (
        .clk          (clk),
        .arst_n       (arst_n),
        .s1_val       (s1_val),
        .s1_result    (s1_result),
        .s1_wr_result (s1_wr_result),
        .s1_cc_new    (s1_cc_new),
        .s1_fmask     (s1_fmask),
        .s1_pop       (s1_pop),
        .s1_pop_image (s1_pop_image),
        .cc_inval     (cc_inval),  // Squashes whatever sits in stage 2 this cycle
        .cc_out       (cc_out),
        .result       (result),
        .result_val   (result_val)
    );

endmodule

//--- flag_checker.sv
/*
 * flag_checker: reference model and scoreboard for the flags pipeline
 * Tracks issued ops, predicts EFLAGS and results, reports each test
 */
`timescale 1ns/1ps
`include "x86_flags_consts.svh"

module flag_checker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   val,
    input  x86_flags_pkg::alu_op_e op,
    input  logic [`XF_DATA_W-1:0]  src1,
    input  logic [`XF_DATA_W-1:0]  src2,
    input  logic                   cc_inval,
    input  logic [8*12-1:0]        name,
    input  x86_flags_pkg::eflags_t cc_out,
    input  logic [`XF_DATA_W-1:0]  result,
    input  logic                   result_val,
    output int                     tests,
    output int                     errors,
    output int                     outstanding
);
    import x86_flags_pkg::*;

    typedef struct packed {
        logic [8*12-1:0]       name;
        alu_op_e               op;
        logic [`XF_DATA_W-1:0] a;
        logic [`XF_DATA_W-1:0] b;
    } issue_t;

    issue_t                issued_q[$];  // Ops between issue and commit
    issue_t                cur;
    eflags_t               model_cc;     // Flags as the pipeline should hold them
    eflags_t               exp_cc;
    logic [`XF_DATA_W-1:0] exp_res;
    logic                  exp_rv;
    logic                  chk_pending;  // A commit is waiting for comparison
    logic                  chk_squash;
    logic [8*12-1:0]       chk_name;

    function automatic logic even_parity(input logic [7:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            n += v[i];
        end
        return (n % 2) == 0;
    endfunction

    // x86 flag rules applied to one op on top of the old image
    task automatic predict(input issue_t it, input eflags_t old, output eflags_t nf,
                           output logic [`XF_DATA_W-1:0] r, output logic has_r);
        logic [`XF_DATA_W-1:0] b;
        logic [`XF_DATA_W:0]   wide;
        longint                exact;
        logic                  sub;
        logic                  unit;
        nf    = old;
        r     = '0;
        has_r = 1'b0;
        unit  = (it.op == OP_INC) || (it.op == OP_DEC);
        sub   = (it.op == OP_SUB) || (it.op == OP_CMP) || (it.op == OP_DEC);
        b     = unit ? 32'd1 : it.b;
        case (it.op)
            OP_ADD, OP_SUB, OP_CMP, OP_INC, OP_DEC: begin
                if (sub) begin
                    wide  = {1'b0, it.a} - {1'b0, b};
                    exact = longint'($signed(it.a)) - longint'($signed(b));
                end else begin
                    wide  = {1'b0, it.a} + {1'b0, b};
                    exact = longint'($signed(it.a)) + longint'($signed(b));
                end
                r = wide[`XF_DATA_W-1:0];
                if (!unit) begin
                    nf[`XF_CF_BIT] = sub ? (it.a < b) : wide[`XF_DATA_W];
                end
                nf[`XF_AF_BIT] = sub ? (it.a[3:0] < b[3:0]) : ((it.a[3:0] + b[3:0]) > 15);
                nf[`XF_OF_BIT] = (exact != longint'($signed(r)));  // Result does not fit
                has_r = (it.op != OP_CMP);
            end
            OP_AND, OP_OR, OP_XOR: begin
                if (it.op == OP_AND) r = it.a & it.b;
                else if (it.op == OP_OR) r = it.a | it.b;
                else r = it.a ^ it.b;
                nf[`XF_CF_BIT] = 1'b0;
                nf[`XF_OF_BIT] = 1'b0;
                has_r = 1'b1;
            end
            OP_CLD:  nf[`XF_DF_BIT] = 1'b0;
            OP_STD:  nf[`XF_DF_BIT] = 1'b1;
            OP_POPF: nf = it.b[`XF_EFLAGS_W-1:0] & `XF_DEFINED_MASK;
            default: nf = old;
        endcase
        if (has_r || it.op == OP_CMP) begin
            nf[`XF_PF_BIT] = even_parity(r[7:0]);
            nf[`XF_ZF_BIT] = (r == 0);
            nf[`XF_SF_BIT] = r[`XF_DATA_W-1];
        end
    endtask

    initial begin
        tests       = 0;
        errors      = 0;
        outstanding = 0;
        chk_pending = 1'b0;
    end

    // Model follows the DUT edge by edge, inputs seen as the DUT samples them
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issued_q.delete();
            model_cc    = '0;
            chk_pending = 1'b0;
            outstanding = 0;
        end else begin
            if (issued_q.size() != 0) begin
                cur = issued_q.pop_front();
                predict(cur, model_cc, exp_cc, exp_res, exp_rv);
                chk_squash = cc_inval;
                if (cc_inval) begin
                    exp_cc = model_cc;
                    exp_rv = 1'b0;
                end
                model_cc    = exp_cc;
                chk_name    = cur.name;
                chk_pending = 1'b1;
            end
            if (val) begin
                issued_q.push_back({name, op, src1, src2});
            end
            outstanding = issued_q.size() + chk_pending;
        end
    end

    always @(posedge arst_n) begin
        tests++;
        if (cc_out !== '0) begin
            $display("error reset: cc_out expected %05h actual %05h", 18'h0, cc_out);
            errors++;
        end else if (result_val !== 1'b0) begin
            $display("reset: result_val is not low after reset");
            errors++;
        end else begin
            $display("ok reset");
        end
    end

    // Outputs are settled half a cycle after the commit edge
    always @(negedge clk) begin
        if (chk_pending) begin
            tests++;
            if (cc_out !== exp_cc) begin
                $display("error %0s: cc_out expected %05h actual %05h", chk_name, exp_cc, cc_out);
                errors++;
            end else if (exp_rv && result_val !== 1'b1) begin
                $display("%0s: result_val pulse is missing", chk_name);
                errors++;
            end else if (!exp_rv && result_val !== 1'b0) begin
                $display("%0s: result_val pulsed but no result was due", chk_name);
                errors++;
            end else if (exp_rv && result !== exp_res) begin
                $display("error %0s: result expected %08h actual %08h", chk_name, exp_res, result);
                errors++;
            end else begin
                $display("ok %0s cc_out=%05h%s", chk_name, cc_out, chk_squash ? " squashed" : "");
            end
            chk_pending = 1'b0;
            outstanding = issued_q.size();
        end else if (arst_n && result_val === 1'b1) begin
            $display("result_val pulsed with no operation committing");
            errors++;
        end
    end

endmodule

//--- tb_x86_flags.sv
/*
 * tb_x86_flags: testbench for the two-stage flags pipeline
 * Applies a stimulus table, flag_checker does the comparing
 */
`timescale 1ns/1ps
`include "x86_flags_consts.svh"

module tb_x86_flags;
    import x86_flags_pkg::*;

    localparam int MAX_ENTRIES = 64;

    logic                  clk;
    logic                  arst_n;
    logic                  val;
    alu_op_e               op;
    logic [`XF_DATA_W-1:0] src1;
    logic [`XF_DATA_W-1:0] src2;
    logic                  cc_inval;
    logic [8*12-1:0]       cur_name;  // Name of the op being issued
    eflags_t               cc_out;
    logic [`XF_DATA_W-1:0] result;
    logic                  result_val;
    int                    tests;
    int                    errors;
    int                    outstanding;

    // Stimulus table
    logic [8*12-1:0]       tbl_name  [MAX_ENTRIES];
    alu_op_e               tbl_op    [MAX_ENTRIES];
    logic [`XF_DATA_W-1:0] tbl_a     [MAX_ENTRIES];
    logic [`XF_DATA_W-1:0] tbl_b     [MAX_ENTRIES];
    logic                  tbl_inval [MAX_ENTRIES];
    int                    tbl_gap   [MAX_ENTRIES];
    int                    n_entries;
    int                    limit;
    int                    cycles;
    int                    seed;
    logic                  next_inval;  // Squash for the op issued one cycle earlier

    x86_flags_top uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .val        (val),
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .cc_inval   (cc_inval),
        .cc_out     (cc_out),
        .result     (result),
        .result_val (result_val)
    );

    flag_checker u_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .val         (val),
        .op          (op),
        .src1        (src1),
        .src2        (src2),
        .cc_inval    (cc_inval),
        .name        (cur_name),
        .cc_out      (cc_out),
        .result      (result),
        .result_val  (result_val),
        .tests       (tests),
        .errors      (errors),
        .outstanding (outstanding)
    );

    task automatic add_entry(input logic [8*12-1:0] nm, input alu_op_e o,
                             input logic [`XF_DATA_W-1:0] a, input logic [`XF_DATA_W-1:0] b,
                             input logic inv, input int gap);
        tbl_name[n_entries]  = nm;
        tbl_op[n_entries]    = o;
        tbl_a[n_entries]     = a;
        tbl_b[n_entries]     = b;
        tbl_inval[n_entries] = inv;
        tbl_gap[n_entries]   = gap;
        n_entries++;
    endtask

    task automatic build_table();
        add_entry("add_basic", OP_ADD, 32'h5, 32'h3, 1'b0, 1);
        add_entry("add_carry", OP_ADD, 32'hFFFF_FFFF, 32'h1, 1'b0, 1);  // Zero with carry
        add_entry("add_ovf", OP_ADD, 32'h7FFF_FFFF, 32'h1, 1'b0, 1);
        add_entry("sub_zero", OP_SUB, 32'h1234, 32'h1234, 1'b0, 1);
        add_entry("sub_borrow", OP_SUB, 32'h0, 32'h1, 1'b0, 1);
        add_entry("sub_ovf", OP_SUB, 32'h8000_0000, 32'h1, 1'b0, 1);
        add_entry("cmp_eq", OP_CMP, 32'h55, 32'h55, 1'b0, 1);
        add_entry("cmp_lt", OP_CMP, 32'h3, 32'h9, 1'b0, 1);
        add_entry("add_af", OP_ADD, 32'h0F, 32'h1, 1'b0, 1);
        add_entry("and_keep_af", OP_AND, 32'hF0F0, 32'h0FF0, 1'b0, 1);  // AF from add_af
        add_entry("or_zero", OP_OR, 32'h0, 32'h0, 1'b0, 1);
        add_entry("xor_neg", OP_XOR, 32'h8000_0000, 32'hFF00, 1'b0, 1);
        add_entry("sub_set_cf", OP_SUB, 32'h0, 32'h1, 1'b0, 1);
        add_entry("inc_keep_cf", OP_INC, 32'h7FFF_FFFF, 32'h0, 1'b0, 1);
        add_entry("dec_zero", OP_DEC, 32'h1, 32'h0, 1'b0, 1);
        add_entry("inc_wrap", OP_INC, 32'hFFFF_FFFF, 32'h0, 1'b0, 1);
        add_entry("std", OP_STD, 32'h0, 32'h0, 1'b0, 1);
        add_entry("cld", OP_CLD, 32'h0, 32'h0, 1'b0, 1);
        add_entry("popf_all", OP_POPF, 32'h0, 32'hFFFF_FFFF, 1'b0, 1);
        add_entry("popf_df", OP_POPF, 32'h0, 32'h0000_0481, 1'b0, 1);
        add_entry("nop", OP_NOP, 32'h1, 32'h2, 1'b0, 1);
        add_entry("inval_add", OP_ADD, 32'h1, 32'h1, 1'b1, 1);
        add_entry("inval_popf", OP_POPF, 32'h0, 32'h0, 1'b1, 1);
        add_entry("b2b_add", OP_ADD, 32'h10, 32'h20, 1'b0, 0);
        add_entry("b2b_sub", OP_SUB, 32'h5, 32'h6, 1'b0, 0);
        add_entry("b2b_xor", OP_XOR, 32'hAA, 32'h55, 1'b0, 0);
        add_entry("b2b_inc", OP_INC, 32'hFFFF_FFFF, 32'h0, 1'b0, 0);
        add_entry("b2b_inval", OP_SUB, 32'h9, 32'h9, 1'b1, 0);
        add_entry("b2b_cmp", OP_CMP, 32'h8, 32'h8, 1'b0, 0);
        add_entry("b2b_std", OP_STD, 32'h0, 32'h0, 1'b0, 2);
        add_entry("rnd_add", OP_ADD, $urandom, $urandom, 1'b0, 0);
        add_entry("rnd_sub", OP_SUB, $urandom, $urandom, 1'b0, 0);
        add_entry("rnd_and", OP_AND, $urandom, $urandom, 1'b0, 0);
        add_entry("rnd_or", OP_OR, $urandom, $urandom, 1'b0, 0);
        add_entry("rnd_dec", OP_DEC, $urandom, $urandom, 1'b0, 0);
        add_entry("rnd_cmp", OP_CMP, $urandom, $urandom, 1'b0, 1);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit counted from reset release
    always @(posedge clk) begin
        if (arst_n) begin
            cycles++;
            if (cycles > limit) begin
                $display("timeout: run exceeded %0d cycles, %0d checks outstanding",
                         limit, outstanding);
                $display("RESULT: FAIL");
                $finish;
            end
        end
    end

    initial begin
        seed       = $urandom(26056);
        arst_n     = 1'b0;
        val        = 1'b0;
        op         = OP_NOP;
        src1       = '0;
        src2       = '0;
        cc_inval   = 1'b0;
        cur_name   = '0;
        cycles     = 0;
        n_entries  = 0;
        next_inval = 1'b0;
        build_table();
        limit = 20;
        for (int i = 0; i < n_entries; i++) begin
            limit += 1 + tbl_gap[i];
        end

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < n_entries; i++) begin
            @(posedge clk);
            val      <= 1'b1;
            op       <= tbl_op[i];
            src1     <= tbl_a[i];
            src2     <= tbl_b[i];
            cur_name <= tbl_name[i];
            cc_inval <= next_inval;
            next_inval = tbl_inval[i];
            repeat (tbl_gap[i]) begin
                @(posedge clk);
                val      <= 1'b0;
                cc_inval <= next_inval;
                next_inval = 1'b0;
            end
        end
        @(posedge clk);
        val      <= 1'b0;
        cc_inval <= next_inval;
        @(posedge clk);
        cc_inval <= 1'b0;

        while (outstanding != 0) begin
            @(posedge clk);
        end
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0 && tests > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
x86_flags_pkg.sv
flag_gen.sv
alu_flag_stage.sv
eflags_reg.sv
x86_flags_top.sv
flag_checker.sv
tb_x86_flags.sv

//--- Bender.yml
package:
  name: x86_flags

export_include_dirs:
  - .

sources:
  - files:
      - x86_flags_pkg.sv
      - flag_gen.sv
      - alu_flag_stage.sv
      - eflags_reg.sv
      - x86_flags_top.sv
  - target: test
    files:
      - flag_checker.sv
      - tb_x86_flags.sv
